/* fp_format_pkg.sv */
// Single-precision float word layout, true/false result words
// and sign-magnitude ordering and equality helpers
package fp_format_pkg;

    localparam int exp_width  = 8;
    localparam int mant_width = 23;
    localparam int word_width = 1 + exp_width + mant_width;
    localparam int sign_bit   = word_width - 1;

    typedef logic [word_width-1:0] fp_word_t;

    // Boolean results as float words
    localparam fp_word_t fp_true  = 32'h3f800000;
    localparam fp_word_t fp_false = 32'h00000000;

    ////////////////////////////////////////////////////
    // Ordering on raw words
    ////////////////////////////////////////////////////

    // True when a orders below b, with plus and minus zero equal
    function automatic logic fp_less(input fp_word_t a, input fp_word_t b);
        logic [sign_bit-1:0] mag_a;
        logic [sign_bit-1:0] mag_b;
        logic                less;
        mag_a = a[sign_bit-1:0];
        mag_b = b[sign_bit-1:0];
        if (mag_a == '0 && mag_b == '0) begin
            less = 1'b0;
        end else if (a[sign_bit] != b[sign_bit]) begin
            // Differing signs, the negative one is lower
            less = a[sign_bit];
        end else if (a[sign_bit]) begin
            less = mag_a > mag_b;
        end else begin
            less = mag_a < mag_b;
        end
        return less;
    endfunction

    function automatic logic fp_equal(input fp_word_t a, input fp_word_t b);
        logic both_zero;
        both_zero = (a[sign_bit-1:0] == '0) && (b[sign_bit-1:0] == '0);
        return (a == b) || both_zero;
    endfunction

endpackage

/* alu_isa_pkg.sv */
// ALU instruction set: opcode encodings, field widths
// and the tagged stream struct for operands and results
package alu_isa_pkg;

    localparam int opcode_width   = 8;
    localparam int reg_addr_width = 8;

    ////////////////////////////////////////////////////
    // Opcode encodings
    ////////////////////////////////////////////////////

    // Unlisted opcodes are no-ops
    localparam logic [opcode_width-1:0] abs  = 8'h01;
    localparam logic [opcode_width-1:0] csel = 8'h02;
    localparam logic [opcode_width-1:0] land = 8'h03;
    localparam logic [opcode_width-1:0] lor  = 8'h04;
    localparam logic [opcode_width-1:0] lxor = 8'h05;
    localparam logic [opcode_width-1:0] lnot = 8'h06;
    localparam logic [opcode_width-1:0] bgt  = 8'h07;
    localparam logic [opcode_width-1:0] ble  = 8'h08;
    localparam logic [opcode_width-1:0] beq  = 8'h09;
    localparam logic [opcode_width-1:0] bne  = 8'h0a;
    localparam logic [opcode_width-1:0] satp = 8'h0b;
    localparam logic [opcode_width-1:0] satn = 8'h0c;
    localparam logic [opcode_width-1:0] ldc  = 8'h0d;

    // Operand or result word tagged with its destination register
    typedef struct packed {
        logic                      valid;
        fp_format_pkg::fp_word_t   data;
        logic [reg_addr_width-1:0] user;
    } alu_stream_t;

endpackage

/* fp_compare_unit.sv */
// Float comparison unit: greater-than, less-or-equal,
// equal and not-equal, one cycle latency
`timescale 1ns/1ns

module fp_compare_unit (
    input  logic                                   clock,
    input  logic                                   rst,
    input  logic [alu_isa_pkg::opcode_width-1:0]   opcode,
    input  alu_isa_pkg::alu_stream_t               operand_a,
    input  alu_isa_pkg::alu_stream_t               operand_b,
    output alu_isa_pkg::alu_stream_t               comparison_result
);

    logic is_compare;
    logic a_less_b;
    logic b_less_a;
    logic a_equal_b;
    logic outcome;

    assign is_compare = (opcode == alu_isa_pkg::bgt) || (opcode == alu_isa_pkg::ble) ||
                        (opcode == alu_isa_pkg::beq) || (opcode == alu_isa_pkg::bne);

    assign a_less_b  = fp_format_pkg::fp_less(operand_a.data, operand_b.data);
    assign b_less_a  = fp_format_pkg::fp_less(operand_b.data, operand_a.data);
    assign a_equal_b = fp_format_pkg::fp_equal(operand_a.data, operand_b.data);

    // Pick the relation asked for by the opcode
    always_comb begin
        case (opcode)
            alu_isa_pkg::bgt: outcome = b_less_a;
            alu_isa_pkg::ble: outcome = a_less_b || a_equal_b;
            alu_isa_pkg::beq: outcome = a_equal_b;
            alu_isa_pkg::bne: outcome = !a_equal_b;
            default:          outcome = 1'b0;
        endcase
    end

    ////////////////////////////////////////////////////
    // Result register
    ////////////////////////////////////////////////////

    // Idle cycles leave an all-zero word for the combiner OR
    always_ff @(posedge clock) begin
        if (rst) begin
            comparison_result <= '0;
        end else begin
            comparison_result <= '0;
            if (operand_a.valid && is_compare) begin
                comparison_result.valid <= 1'b1;
                comparison_result.user  <= operand_a.user;
                if (outcome) begin
                    comparison_result.data <= fp_format_pkg::fp_true;
                end else begin
                    comparison_result.data <= fp_format_pkg::fp_false;
                end
            end
        end
    end

endmodule

/* fp_saturator.sv */
// Float saturator: clamps operand a against the limit in operand b
`timescale 1ns/1ns

module fp_saturator (
    input  logic                                   clock,
    input  logic                                   rst,
    input  logic [alu_isa_pkg::opcode_width-1:0]   opcode,
    input  alu_isa_pkg::alu_stream_t               operand_a,
    input  alu_isa_pkg::alu_stream_t               operand_b,
    output alu_isa_pkg::alu_stream_t               saturation_result
);

    logic                    is_saturate;
    logic                    a_below_limit;
    fp_format_pkg::fp_word_t clamped;

    assign is_saturate = (opcode == alu_isa_pkg::satp) || (opcode == alu_isa_pkg::satn);

    assign a_below_limit = fp_format_pkg::fp_less(operand_a.data, operand_b.data);

    // Positive limit keeps the lesser, negative limit the greater
    always_comb begin
        if (opcode == alu_isa_pkg::satp) begin
            clamped = a_below_limit ? operand_a.data : operand_b.data;
        end else begin
            clamped = a_below_limit ? operand_b.data : operand_a.data;
        end
    end

    ////////////////////////////////////////////////////
    // Result register
    ////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (rst) begin
            saturation_result <= '0;
        end else begin
            saturation_result <= '0;
            if (operand_a.valid && is_saturate) begin
                saturation_result.valid <= 1'b1;
                saturation_result.data  <= clamped;
                saturation_result.user  <= operand_a.user;
            end
        end
    end

endmodule

/* logic_unit.sv */
// Bitwise logic unit: AND, OR, XOR of a and b, NOT of a
`timescale 1ns/1ns

module logic_unit (
    input  logic                                   clock,
    input  logic                                   rst,
    input  logic [alu_isa_pkg::opcode_width-1:0]   opcode,
    input  alu_isa_pkg::alu_stream_t               operand_a,
    input  alu_isa_pkg::alu_stream_t               operand_b,
    output alu_isa_pkg::alu_stream_t               logic_result
);

    logic                    is_logic;
    fp_format_pkg::fp_word_t bitwise;

    always_comb begin
        is_logic = 1'b1;
        case (opcode)
            alu_isa_pkg::land: bitwise = operand_a.data & operand_b.data;
            alu_isa_pkg::lor:  bitwise = operand_a.data | operand_b.data;
            alu_isa_pkg::lxor: bitwise = operand_a.data ^ operand_b.data;
            alu_isa_pkg::lnot: bitwise = ~operand_a.data;
            default: begin
                is_logic = 1'b0;
                bitwise  = '0;
            end
        endcase
    end

    ////////////////////////////////////////////////////
    // Result register
    ////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (rst) begin
            logic_result <= '0;
        end else begin
            logic_result <= '0;
            if (operand_a.valid && is_logic) begin
                logic_result.valid <= 1'b1;
                logic_result.data  <= bitwise;
                logic_result.user  <= operand_a.user;
            end
        end
    end

endmodule

/* alu_results_combiner.sv */
// Result combiner: merges the per-unit result streams
// into the single registered ALU result
`timescale 1ns/1ns

module alu_results_combiner (
    input  logic                     clock,
    input  logic                     rst,
    input  alu_isa_pkg::alu_stream_t compare_result,
    input  alu_isa_pkg::alu_stream_t saturation_result,
    input  alu_isa_pkg::alu_stream_t logic_result,
    input  alu_isa_pkg::alu_stream_t abs_result,
    input  alu_isa_pkg::alu_stream_t csel_result,
    input  alu_isa_pkg::alu_stream_t load_result,
    output alu_isa_pkg::alu_stream_t result
);

    alu_isa_pkg::alu_stream_t merged;

    // At most one unit is valid and idle units drive zeros,
    // so a plain OR acts as the mux
    always_comb begin
        merged.valid = compare_result.valid | saturation_result.valid |
                       logic_result.valid | abs_result.valid |
                       csel_result.valid | load_result.valid;
        merged.data  = compare_result.data | saturation_result.data |
                       logic_result.data | abs_result.data |
                       csel_result.data | load_result.data;
        merged.user  = compare_result.user | saturation_result.user |
                       logic_result.user | abs_result.user |
                       csel_result.user | load_result.user;
    end

    ////////////////////////////////////////////////////
    // Output register
    ////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (rst) begin
            result <= '0;
        end else begin
            result <= merged;
        end
    end

endmodule

/* fp_alu.sv */
// Scalar float ALU top: compare, saturate and logic units,
// in-line abs, select and load-constant stages, result combiner
`timescale 1ns/1ns

module fp_alu (
    input  logic                                   clock,
    input  logic                                   rst,
    input  logic [alu_isa_pkg::opcode_width-1:0]   opcode,
    input  alu_isa_pkg::alu_stream_t               operand_a,
    input  alu_isa_pkg::alu_stream_t               operand_b,
    input  alu_isa_pkg::alu_stream_t               operand_c,
    output alu_isa_pkg::alu_stream_t               result
);

    alu_isa_pkg::alu_stream_t compare_result;
    alu_isa_pkg::alu_stream_t saturation_result;
    alu_isa_pkg::alu_stream_t logic_result;
    alu_isa_pkg::alu_stream_t abs_result;
    alu_isa_pkg::alu_stream_t csel_result;
    alu_isa_pkg::alu_stream_t load_result;

    // Units decode their own opcodes
    fp_compare_unit u_fp_compare_unit (
        .clock             (clock),
        .rst               (rst),
        .opcode            (opcode),
        .operand_a         (operand_a),
        .operand_b         (operand_b),
        .comparison_result (compare_result)
    );

    fp_saturator u_fp_saturator (
        .clock             (clock),
        .rst               (rst),
        .opcode            (opcode),
        .operand_a         (operand_a),
        .operand_b         (operand_b),
        .saturation_result (saturation_result)
    );

    logic_unit u_logic_unit (
        .clock        (clock),
        .rst          (rst),
        .opcode       (opcode),
        .operand_a    (operand_a),
        .operand_b    (operand_b),
        .logic_result (logic_result)
    );

    ////////////////////////////////////////////////////
    // Absolute value
    ////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (rst) begin
            abs_result <= '0;
        end else begin
            abs_result <= '0;
            if (operand_a.valid && opcode == alu_isa_pkg::abs) begin
                abs_result.valid <= 1'b1;
                abs_result.data  <= {1'b0, operand_a.data[fp_format_pkg::sign_bit-1:0]};
                abs_result.user  <= operand_a.user;
            end
        end
    end

    ////////////////////////////////////////////////////
    // Conditional select
    ////////////////////////////////////////////////////

    // Bit 0 of a picks b, otherwise c
    always_ff @(posedge clock) begin
        if (rst) begin
            csel_result <= '0;
        end else begin
            csel_result <= '0;
            if (operand_a.valid && opcode == alu_isa_pkg::csel) begin
                csel_result.valid <= 1'b1;
                csel_result.data  <= operand_a.data[0] ? operand_b.data : operand_c.data;
                csel_result.user  <= operand_a.user;
            end
        end
    end

    ////////////////////////////////////////////////////
    // Load constant
    ////////////////////////////////////////////////////

    // Register tag doubles as the constant, zero extended
    always_ff @(posedge clock) begin
        if (rst) begin
            load_result <= '0;
        end else begin
            load_result <= '0;
            if (operand_a.valid && opcode == alu_isa_pkg::ldc) begin
                load_result.valid <= 1'b1;
                load_result.data  <= fp_format_pkg::fp_word_t'(operand_a.user);
                load_result.user  <= operand_a.user;
            end
        end
    end

    alu_results_combiner u_alu_results_combiner (
        .clock             (clock),
        .rst               (rst),
        .compare_result    (compare_result),
        .saturation_result (saturation_result),
        .logic_result      (logic_result),
        .abs_result        (abs_result),
        .csel_result       (csel_result),
        .load_result       (load_result),
        .result            (result)
    );

endmodule

/* fp_alu_checker.sv */
// Bound assertions on fp_alu: two-cycle result latency,
// no-op silence, unit exclusivity and reset clearing
`timescale 1ns/1ns

module fp_alu_checker (
    input logic                                 clock,
    input logic                                 rst,
    input logic [alu_isa_pkg::opcode_width-1:0] opcode,
    input alu_isa_pkg::alu_stream_t             operand_a,
    input alu_isa_pkg::alu_stream_t             result,
    input alu_isa_pkg::alu_stream_t             compare_result,
    input alu_isa_pkg::alu_stream_t             saturation_result,
    input alu_isa_pkg::alu_stream_t             logic_result,
    input alu_isa_pkg::alu_stream_t             abs_result,
    input alu_isa_pkg::alu_stream_t             csel_result,
    input alu_isa_pkg::alu_stream_t             load_result
);

    logic known_opcode;
    logic issued_known;
    logic issued_unknown;
    logic latency_bad  = 1'b0;
    logic spurious_bad = 1'b0;
    logic noop_bad     = 1'b0;
    logic overlap_bad  = 1'b0;
    logic reset_bad    = 1'b0;
    logic failed;

    assign known_opcode = opcode inside {alu_isa_pkg::abs, alu_isa_pkg::csel,
        alu_isa_pkg::land, alu_isa_pkg::lor, alu_isa_pkg::lxor, alu_isa_pkg::lnot,
        alu_isa_pkg::bgt, alu_isa_pkg::ble, alu_isa_pkg::beq, alu_isa_pkg::bne,
        alu_isa_pkg::satp, alu_isa_pkg::satn, alu_isa_pkg::ldc};
    assign issued_known   = operand_a.valid && known_opcode;
    assign issued_unknown = operand_a.valid && !known_opcode;
    assign failed = latency_bad | spurious_bad | noop_bad | overlap_bad | reset_bad;

    //////////////////////////////////////////////////
    // Result timing
    //////////////////////////////////////////////////

    latency_check: assert property (@(posedge clock) disable iff (rst)
        issued_known |-> ##2 result.valid)
        else begin
            $error("result.valid missing two cycles after a known opcode");
            latency_bad = 1'b1;
        end

    // Every result traces back to an issue two cycles earlier
    spurious_check: assert property (@(posedge clock) disable iff (rst)
        result.valid |-> $past(issued_known, 2))
        else begin
            $error("result.valid without a known opcode issued two cycles before");
            spurious_bad = 1'b1;
        end

    noop_check: assert property (@(posedge clock) disable iff (rst)
        issued_unknown |-> ##2 !result.valid)
        else begin
            $error("no-op opcode produced a result");
            noop_bad = 1'b1;
        end

    //////////////////////////////////////////////////
    // Unit exclusivity and reset
    //////////////////////////////////////////////////

    overlap_check: assert property (@(posedge clock) disable iff (rst)
        $onehot0({compare_result.valid, saturation_result.valid, logic_result.valid,
                  abs_result.valid, csel_result.valid, load_result.valid}))
        else begin
            $error("more than one unit result valid in the same cycle");
            overlap_bad = 1'b1;
        end

    reset_check: assert property (@(posedge clock) rst |=> !result.valid)
        else begin
            $error("result.valid set in the cycle after reset");
            reset_bad = 1'b1;
        end

endmodule

/* tb_fp_alu.sv */
// Directed testbench for fp_alu: clock and reset, one task per opcode group,
// per-cycle result schedule checked on the falling edge, cycle timeout
`timescale 1ns/1ns

module tb_fp_alu;

    localparam int          cycle_limit = 400;
    localparam logic [31:0] one_word    = 32'h3f800000;

    logic                                 clock = 1'b0;
    logic                                 rst;
    logic [alu_isa_pkg::opcode_width-1:0] opcode;
    alu_isa_pkg::alu_stream_t             operand_a;
    alu_isa_pkg::alu_stream_t             operand_b;
    alu_isa_pkg::alu_stream_t             operand_c;
    alu_isa_pkg::alu_stream_t             result;

    int         cycle   = 0;
    logic [7:0] tag_seq = 8'h11;

    // Expected output keyed by the cycle it must appear in
    alu_isa_pkg::alu_stream_t expected [int];

    fp_alu u_fp_alu (
        .clock     (clock),
        .rst       (rst),
        .opcode    (opcode),
        .operand_a (operand_a),
        .operand_b (operand_b),
        .operand_c (operand_c),
        .result    (result)
    );

    bind fp_alu fp_alu_checker u_fp_alu_checker (.*);

    always #2 clock = ~clock;

    always @(posedge clock) begin
        cycle <= cycle + 1;
        if (cycle >= cycle_limit) begin
            $display("Timeout: tests still running after %0d cycles", cycle_limit);
            $display("FAIL: see errors above");
            $fatal(1, "timeout");
        end
    end

    always @(negedge clock) begin
        check_result();
    end

    //////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////

    // Position on the float line, both zeros at 0
    function automatic logic signed [32:0] order_rank(input logic [31:0] w);
        logic signed [32:0] mag;
        mag = $signed({2'b00, w[30:0]});
        return w[31] ? -mag : mag;
    endfunction

    function automatic alu_isa_pkg::alu_stream_t reference_result(
        input logic [7:0] op, input logic [31:0] a, input logic [31:0] b,
        input logic [31:0] c, input logic [7:0] tag);
        alu_isa_pkg::alu_stream_t r;
        logic                     a_lt_b;
        logic                     b_lt_a;
        logic                     a_eq_b;
        a_lt_b  = order_rank(a) < order_rank(b);
        b_lt_a  = order_rank(b) < order_rank(a);
        a_eq_b  = order_rank(a) == order_rank(b);
        r.valid = 1'b1;
        r.user  = tag;
        case (op)
            alu_isa_pkg::abs:  r.data = {1'b0, a[30:0]};
            alu_isa_pkg::csel: r.data = a[0] ? b : c;
            alu_isa_pkg::land: r.data = a & b;
            alu_isa_pkg::lor:  r.data = a | b;
            alu_isa_pkg::lxor: r.data = a ^ b;
            alu_isa_pkg::lnot: r.data = ~a;
            alu_isa_pkg::bgt:  r.data = b_lt_a ? one_word : 32'h0;
            alu_isa_pkg::ble:  r.data = (a_lt_b || a_eq_b) ? one_word : 32'h0;
            alu_isa_pkg::beq:  r.data = a_eq_b ? one_word : 32'h0;
            alu_isa_pkg::bne:  r.data = a_eq_b ? 32'h0 : one_word;
            alu_isa_pkg::satp: r.data = a_lt_b ? a : b;
            alu_isa_pkg::satn: r.data = a_lt_b ? b : a;
            alu_isa_pkg::ldc:  r.data = {24'h0, tag};
            default:           r = '0;
        endcase
        return r;
    endfunction

    //////////////////////////////////////////////////
    // Drive and check
    //////////////////////////////////////////////////

    task automatic fail_value(input string name, input logic [31:0] want,
                              input logic [31:0] got);
        $display("[FAIL] time %0t: %s expected %h got %h", $time, name, want, got);
        $display("FAIL: see errors above");
        $fatal(1, "result mismatch");
    endtask

    task automatic fail_plain(input string why);
        $display("%s", why);
        $display("FAIL: see errors above");
        $fatal(1, "checker failure");
    endtask

    task automatic check_result();
        alu_isa_pkg::alu_stream_t want;
        want = '0;
        if (expected.exists(cycle)) begin
            want = expected[cycle];
        end
        assert (result.valid === want.valid)
            else fail_value("result.valid", 32'(want.valid), 32'(result.valid));
        if (want.valid) begin
            assert (result.data === want.data)
                else fail_value("result.data", want.data, result.data);
            assert (result.user === want.user)
                else fail_value("result.user", 32'(want.user), 32'(result.user));
        end
        assert (u_fp_alu.u_fp_alu_checker.failed === 1'b0)
            else fail_plain("A bound assertion on fp_alu timing or exclusivity failed");
    endtask

    // One instruction per call, result due two edges later
    task automatic issue(input logic [7:0] op, input logic [31:0] a, input logic [31:0] b,
                         input logic [31:0] c);
        opcode    = op;
        operand_a = {1'b1, a, tag_seq};
        operand_b = {1'b1, b, tag_seq};
        operand_c = {1'b1, c, tag_seq};
        expected[cycle + 2] = reference_result(op, a, b, c, tag_seq);
        tag_seq = tag_seq + 8'd37;
        @(posedge clock);
        #1;
    endtask

    // Valid low with a live opcode must stay silent
    task automatic idle(input int n);
        opcode          = alu_isa_pkg::ldc;
        operand_a.valid = 1'b0;
        operand_b.valid = 1'b0;
        operand_c.valid = 1'b0;
        repeat (n) begin
            @(posedge clock);
            #1;
        end
    endtask

    //////////////////////////////////////////////////
    // Directed tests
    //////////////////////////////////////////////////

    task automatic idle_and_noop_test();
        idle(4);
        issue(8'h00, $urandom, $urandom, $urandom);
        issue(8'h0e, $urandom, $urandom, $urandom);
        issue(8'hff, $urandom, $urandom, $urandom);
        idle(3);
    endtask

    task automatic abs_csel_test();
        logic [31:0] a;
        int          i;
        for (i = 0; i < 4; i++) begin
            a     = $urandom;
            a[31] = ~i[0];
            issue(alu_isa_pkg::abs, a, $urandom, $urandom);
            a[0] = i[0];
            issue(alu_isa_pkg::csel, a, $urandom, $urandom);
        end
        idle(3);
    endtask

    task automatic logic_test();
        logic [31:0] a;
        logic [31:0] b;
        int          i;
        for (i = 0; i < 4; i++) begin
            a = $urandom;
            b = $urandom;
            issue(alu_isa_pkg::land, a, b, 32'h0);
            issue(alu_isa_pkg::lor, a, b, 32'h0);
            issue(alu_isa_pkg::lxor, a, b, 32'h0);
            issue(alu_isa_pkg::lnot, a, b, 32'h0);
        end
        idle(3);
    endtask

    task automatic compare_test();
        logic [31:0] a;
        logic [31:0] b;
        int          i;
        for (i = 0; i < 6; i++) begin
            a = $urandom;
            b = $urandom;
            if (i == 2) begin
                b = a | 32'h80000000;
            end
            // Plus zero against minus zero
            if (i == 3) begin
                a = 32'h00000000;
                b = 32'h80000000;
            end
            if (i == 4) begin
                b = a;
            end
            if (i == 5) begin
                a = 32'hbf800000;
                b = 32'h3f800000;
            end
            issue(alu_isa_pkg::bgt, a, b, 32'h0);
            issue(alu_isa_pkg::ble, a, b, 32'h0);
            issue(alu_isa_pkg::beq, a, b, 32'h0);
            issue(alu_isa_pkg::bne, a, b, 32'h0);
        end
        idle(3);
    endtask

    task automatic saturate_load_test();
        logic [31:0] a;
        logic [31:0] b;
        int          i;
        for (i = 0; i < 4; i++) begin
            a = $urandom;
            b = $urandom;
            // 2.0 against a limit of 1.0
            if (i == 0) begin
                a = 32'h40000000;
                b = 32'h3f800000;
            end
            issue(alu_isa_pkg::satp, a, b, 32'h0);
            issue(alu_isa_pkg::satn, a, b, 32'h0);
            issue(alu_isa_pkg::ldc, a, b, 32'h0);
        end
        idle(3);
    endtask

    task automatic back_to_back_test();
        issue(alu_isa_pkg::abs, 32'hc0490fdb, $urandom, $urandom);
        issue(alu_isa_pkg::ldc, $urandom, $urandom, $urandom);
        issue(alu_isa_pkg::satp, $urandom, $urandom, $urandom);
        issue(alu_isa_pkg::lxor, $urandom, $urandom, $urandom);
        issue(alu_isa_pkg::bne, $urandom, $urandom, $urandom);
        issue(alu_isa_pkg::csel, $urandom, $urandom, $urandom);
        issue(8'h00, $urandom, $urandom, $urandom);
        issue(alu_isa_pkg::land, $urandom, $urandom, $urandom);
        idle(3);
    endtask

    initial begin
        void'($urandom(32'h83a7e8fb));
        rst       = 1'b1;
        opcode    = '0;
        operand_a = '0;
        operand_b = '0;
        operand_c = '0;
        repeat (10) @(posedge clock);
        #1;
        rst = 1'b0;
        idle_and_noop_test();
        abs_csel_test();
        logic_test();
        compare_test();
        saturate_load_test();
        back_to_back_test();
        $display("PASS: all tests");
        $finish;
    end

endmodule

/* list.f */
fp_format_pkg.sv
alu_isa_pkg.sv
fp_compare_unit.sv
fp_saturator.sv
logic_unit.sv
alu_results_combiner.sv
fp_alu.sv
fp_alu_checker.sv
tb_fp_alu.sv

/* Makefile */
# Verilator build and run of the fp_alu testbench, plus lint and clean

VERILATOR ?= verilator
TOP       ?= tb_fp_alu
FILE_LIST ?= list.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+100

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)

run: build
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS)

lint:
	$(VERILATOR) --lint-only --timing -Wall --top-module $(TOP) -f $(FILE_LIST)

clean:
	rm -rf $(BUILD_DIR)
